// ==== filelist.f ====
+incdir+.
rec_pkg.sv
rec_cmd_seq.sv
rec_csr_regs.sv
rec_fifo_track.sv
rec_resp_mux.sv
rec_executor.sv
rec_executor_chk.sv
tb_rec_executor.sv

// ==== rec_cfg.svh ====
// Depth and transfer size are fixed at build time and must match the external indirect FIFO
`ifndef REC_CFG_SVH
`define REC_CFG_SVH

// Indirect FIFO depth in 32-bit words
`define REC_FIFO_DEPTH 32'd64

// Reported maximum transfer size in words
`define REC_MAX_XFER_WORDS 32'd64

// Value of the activate byte that starts the recovery image
`define REC_ACTIVATE_CODE 8'h0F

// Recovery command code range
`define REC_CMD_MIN 8'd34
`define REC_CMD_MAX 8'd47

// Codes above this one need recovery mode
`define REC_CMD_OPEN_MAX 8'd39

`endif

// ==== rec_cmd_seq.sv ====
// One command at a time; upstream must wait for cmd_done_o and TTI acks never coincide with requests
`timescale 1ns/10ps
`include "rec_cfg.svh"

module rec_cmd_seq (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  rec_pkg::cmd_req_t     cmd_i,
  input  logic                  recovery_mode_enabled_i,
  input  logic                  host_abort_i,
  input  logic                  tti_rx_rack_i,
  input  rec_pkg::word_t        tti_rx_rdata_i,
  input  logic                  res_ready_i,
  input  logic                  res_dready_i,
  output logic                  tti_rx_rreq_o,
  output rec_pkg::csr_wr_t      csr_wr_o,
  output logic                  fifo_push_o,
  output rec_pkg::csr_sel_e     sel_o,
  output logic [1:0]            byte_idx_o,
  output logic                  res_valid_o,
  output rec_pkg::len_t         res_len_o,
  output logic                  res_dvalid_o,
  output logic                  res_dlast_o,
  output logic                  cmd_done_o,
  output logic                  rx_queue_clr_o
);

  rec_pkg::seq_state_e state_q;
  rec_pkg::seq_state_e state_d;
  rec_pkg::csr_sel_e   sel_q;
  rec_pkg::csr_sel_e   start_sel;
  rec_pkg::len_t       cnt_q;
  rec_pkg::len_t       reg_len;
  rec_pkg::len_t       wr_words;
  logic [1:0]          byte_idx_q;
  logic                kept;
  logic                legal;
  logic                is_fifo_data;
  logic                rd_beat;

  // Step to the next word of a multi-word register and park on INVALID
  function automatic rec_pkg::csr_sel_e next_sel(rec_pkg::csr_sel_e sel);
    rec_pkg::csr_sel_e nxt;
    case (sel)
      rec_pkg::SEL_FIFO_CTRL_0:   nxt = rec_pkg::SEL_FIFO_CTRL_1;
      rec_pkg::SEL_FIFO_STATUS_0: nxt = rec_pkg::SEL_FIFO_STATUS_1;
      rec_pkg::SEL_FIFO_STATUS_1: nxt = rec_pkg::SEL_FIFO_STATUS_2;
      rec_pkg::SEL_FIFO_STATUS_2: nxt = rec_pkg::SEL_FIFO_STATUS_3;
      rec_pkg::SEL_FIFO_STATUS_3: nxt = rec_pkg::SEL_FIFO_STATUS_4;
      default:                    nxt = rec_pkg::SEL_INVALID;
    endcase
    return nxt;
  endfunction

  // Code to first selector and register length
  always_comb begin
    kept      = 1'b1;
    start_sel = rec_pkg::SEL_INVALID;
    reg_len   = 16'd0;
    case (cmd_i.code)
      rec_pkg::CMD_DEVICE_RESET: begin
        start_sel = rec_pkg::SEL_DEVICE_RESET;
        reg_len   = 16'd3;
      end
      rec_pkg::CMD_RECOVERY_CTRL: begin
        start_sel = rec_pkg::SEL_RECOVERY_CTRL;
        reg_len   = 16'd3;
      end
      rec_pkg::CMD_INDIRECT_FIFO_CTRL: begin
        start_sel = rec_pkg::SEL_FIFO_CTRL_0;
        reg_len   = 16'd6;
      end
      rec_pkg::CMD_INDIRECT_FIFO_STATUS: begin
        start_sel = rec_pkg::SEL_FIFO_STATUS_0;
        reg_len   = 16'd20;
      end
      rec_pkg::CMD_INDIRECT_FIFO_DATA: ;
      default: kept = 1'b0;
    endcase
  end

  assign is_fifo_data = (cmd_i.code == rec_pkg::CMD_INDIRECT_FIFO_DATA);
  assign legal = !cmd_i.err && kept
               && (recovery_mode_enabled_i || (cmd_i.code <= `REC_CMD_OPEN_MAX))
               && !(cmd_i.is_rd && is_fifo_data);

  // Payload words, rounded up
  assign wr_words = rec_pkg::len_t'((17'(cmd_i.len) + 17'd3) >> 2);
  assign rd_beat  = (state_q == rec_pkg::ReadData) && res_dready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rec_pkg::Idle: begin
        if (cmd_valid_i) begin
          if (!legal) state_d = rec_pkg::Error;
          else if (cmd_i.is_rd) state_d = rec_pkg::ReadWait;
          else if (wr_words == 16'd0) state_d = rec_pkg::Done;
          else if (is_fifo_data) state_d = rec_pkg::FifoWrite;
          else state_d = rec_pkg::CsrWrite;
        end
      end
      rec_pkg::CsrWrite, rec_pkg::FifoWrite: begin
        if (tti_rx_rack_i && (cnt_q == 16'd1)) state_d = rec_pkg::Done;
      end
      rec_pkg::ReadWait: begin
        if (res_ready_i) state_d = rec_pkg::ReadLen;
      end
      rec_pkg::ReadLen: state_d = rec_pkg::ReadData;
      rec_pkg::ReadData: begin
        if (host_abort_i) state_d = rec_pkg::Error;
        else if (rd_beat && (cnt_q == 16'd1)) state_d = rec_pkg::Done;
      end
      rec_pkg::Error: state_d = rec_pkg::Done;
      default: state_d = rec_pkg::Idle;
    endcase
  end

  // Counter holds words left on writes and bytes left on reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= rec_pkg::Idle;
      tti_rx_rreq_o <= 1'b0;
      sel_q         <= rec_pkg::SEL_INVALID;
      cnt_q         <= 16'd0;
      byte_idx_q    <= 2'd0;
    end else begin
      state_q       <= state_d;
      tti_rx_rreq_o <= 1'b0;
      case (state_q)
        rec_pkg::Idle: begin
          if (cmd_valid_i) begin
            sel_q         <= start_sel;
            cnt_q         <= cmd_i.is_rd ? reg_len : wr_words;
            byte_idx_q    <= 2'd0;
            tti_rx_rreq_o <= legal && !cmd_i.is_rd && (wr_words != 16'd0);
          end
        end
        rec_pkg::CsrWrite, rec_pkg::FifoWrite: begin
          if (tti_rx_rack_i) begin
            cnt_q         <= cnt_q - 16'd1;
            sel_q         <= next_sel(sel_q);
            tti_rx_rreq_o <= (cnt_q != 16'd1);
          end
        end
        rec_pkg::ReadData: begin
          if (rd_beat) begin
            cnt_q      <= cnt_q - 16'd1;
            byte_idx_q <= byte_idx_q + 2'd1;
            if (byte_idx_q == 2'd3) sel_q <= next_sel(sel_q);
          end
        end
        default: ;
      endcase
    end
  end

  assign csr_wr_o.we    = (state_q == rec_pkg::CsrWrite) && tti_rx_rack_i;
  assign csr_wr_o.sel   = sel_q;
  assign csr_wr_o.data  = tti_rx_rdata_i;
  assign fifo_push_o    = (state_q == rec_pkg::FifoWrite) && tti_rx_rack_i;
  assign sel_o          = sel_q;
  assign byte_idx_o     = byte_idx_q;
  // Counter still holds the full length in ReadLen
  assign res_len_o      = cnt_q;
  assign res_valid_o    = (state_q == rec_pkg::ReadLen);
  assign res_dvalid_o   = (state_q == rec_pkg::ReadData);
  assign res_dlast_o    = (state_q == rec_pkg::ReadData) && (cnt_q == 16'd1);
  assign cmd_done_o     = (state_q == rec_pkg::Done);
  assign rx_queue_clr_o = (state_q == rec_pkg::Error);

endmodule

// ==== rec_csr_regs.sv ====
// Writes to status selectors are dropped; only a FIFO reset byte of 1 clears the indirect FIFO
`timescale 1ns/10ps
`include "rec_cfg.svh"

module rec_csr_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  rec_pkg::csr_wr_t    csr_wr_i,
  output rec_pkg::rec_regs_t  regs_o,
  output logic                fifo_clr_o,
  output logic                image_activated_o
);

  rec_pkg::rec_regs_t regs_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else begin
      // Reset request lasts one cycle
      if (regs_q.fifo_reset != 8'd0) begin
        regs_q.fifo_reset <= 8'd0;
      end

      if (csr_wr_i.we) begin
        case (csr_wr_i.sel)
          rec_pkg::SEL_DEVICE_RESET: begin
            regs_q.device_reset <= csr_wr_i.data[23:0];
          end
          rec_pkg::SEL_RECOVERY_CTRL: begin
            regs_q.recovery_ctrl <= csr_wr_i.data[23:0];
          end
          rec_pkg::SEL_FIFO_CTRL_0: begin
            regs_q.fifo_cms          <= csr_wr_i.data[7:0];
            regs_q.fifo_reset        <= csr_wr_i.data[15:8];
            regs_q.image_size[15:0]  <= csr_wr_i.data[31:16];
          end
          rec_pkg::SEL_FIFO_CTRL_1: begin
            // Upper half of image size sits in the low bytes of the second word
            regs_q.image_size[31:16] <= csr_wr_i.data[15:0];
          end
          default: ;
        endcase
      end
    end
  end

  assign regs_o = regs_q;

  assign fifo_clr_o = (regs_q.fifo_reset == 8'd1);

  // Activate byte is byte 2 of RECOVERY_CTRL
  assign image_activated_o = (regs_q.recovery_ctrl[2] == `REC_ACTIVATE_CODE);

endmodule

// ==== rec_executor.sv ====
// No back-pressure toward the indirect FIFO; the receiver must not overflow it
`timescale 1ns/10ps

module rec_executor (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cmd_valid_i,
  input  rec_pkg::cmd_req_t  cmd_i,
  output logic               cmd_done_o,
  input  logic               recovery_mode_enabled_i,
  input  logic               host_abort_i,
  output logic               tti_rx_rreq_o,
  input  logic               tti_rx_rack_i,
  input  rec_pkg::word_t     tti_rx_rdata_i,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output rec_pkg::len_t      res_len_o,
  output logic               res_dvalid_o,
  input  logic               res_dready_i,
  output rec_pkg::byte_t     res_data_o,
  output logic               res_dlast_o,
  output logic               rx_queue_clr_o,
  output logic               indirect_rx_wvalid_o,
  output rec_pkg::word_t     indirect_rx_wdata_o,
  input  logic               indirect_rx_rack_i,
  input  logic               indirect_rx_full_i,
  input  logic               indirect_rx_empty_i,
  output logic               indirect_rx_clr_o,
  output logic               payload_available_o,
  output logic               image_activated_o
);

  rec_pkg::csr_wr_t      csr_wr;
  rec_pkg::csr_sel_e     sel;
  rec_pkg::rec_regs_t    regs;
  rec_pkg::fifo_status_t fifo_status;
  logic [1:0]            byte_idx;
  logic                  fifo_push;
  logic                  fifo_clr;

  rec_cmd_seq rec_cmd_seq_inst (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_i, .recovery_mode_enabled_i, .host_abort_i,
    .tti_rx_rack_i, .tti_rx_rdata_i, .res_ready_i, .res_dready_i, .tti_rx_rreq_o,
    .csr_wr_o (csr_wr), .fifo_push_o (fifo_push), .sel_o (sel), .byte_idx_o (byte_idx),
    .res_valid_o, .res_len_o, .res_dvalid_o, .res_dlast_o, .cmd_done_o, .rx_queue_clr_o
  );

  rec_csr_regs rec_csr_regs_inst (
    .clk_i, .rst_ni, .csr_wr_i (csr_wr), .regs_o (regs), .fifo_clr_o (fifo_clr),
    .image_activated_o
  );

  rec_fifo_track rec_fifo_track_inst (
    .clk_i, .rst_ni, .push_i (fifo_push), .pop_i (indirect_rx_rack_i), .clr_i (fifo_clr),
    .full_i (indirect_rx_full_i), .empty_i (indirect_rx_empty_i),
    .image_activated_i (image_activated_o), .status_o (fifo_status), .payload_available_o
  );

  rec_resp_mux rec_resp_mux_inst (
    .sel_i (sel), .byte_idx_i (byte_idx), .regs_i (regs), .status_i (fifo_status),
    .res_data_o
  );

  // Payload words go straight through to the indirect FIFO
  assign indirect_rx_wvalid_o = fifo_push;
  assign indirect_rx_wdata_o  = tti_rx_rdata_i;
  assign indirect_rx_clr_o    = fifo_clr;

endmodule

// ==== rec_executor_chk.sv ====
// Bound to rec_executor; checks port handshake rules only, never the data values
`timescale 1ns/10ps

module rec_executor_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic tti_rx_rreq_o,
  input logic tti_rx_rack_i,
  input logic res_dvalid_o,
  input logic res_dready_i,
  input logic host_abort_i,
  input logic cmd_done_o,
  input logic rx_queue_clr_o
);

  // TTI request never overlaps its ack
  req_vs_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tti_rx_rreq_o && tti_rx_rack_i))
    else $error("TTI read request raised while the ack is high");

  // Response data valid holds until ready, unless the host aborts
  dvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_dvalid_o && !res_dready_i && !host_abort_i) |=> res_dvalid_o)
    else $error("Response data valid dropped before ready");

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o |=> !cmd_done_o)
    else $error("Command done strobe lasted more than one cycle");

  // Error path always finishes right after the queue clear
  clr_then_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_clr_o |=> cmd_done_o)
    else $error("RX queue clear was not followed by command done");

endmodule

bind rec_executor rec_executor_chk rec_executor_chk_inst (.*);

// ==== rec_fifo_track.sv ====
// Indices only mirror the external FIFO; push and pop strobes are trusted, no overflow check
`timescale 1ns/10ps
`include "rec_cfg.svh"

module rec_fifo_track (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  logic                   pop_i,
  input  logic                   clr_i,
  input  logic                   full_i,
  input  logic                   empty_i,
  input  logic                   image_activated_i,
  output rec_pkg::fifo_status_t  status_o,
  output logic                   payload_available_o
);

  rec_pkg::fifo_idx_t wr_idx_q;
  rec_pkg::fifo_idx_t rd_idx_q;
  logic               payload_q;

  // Increment with wrap at the FIFO depth
  function automatic rec_pkg::fifo_idx_t bump(rec_pkg::fifo_idx_t idx);
    return (idx == `REC_FIFO_DEPTH - 32'd1) ? 32'd0 : idx + 32'd1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q <= 32'd0;
      rd_idx_q <= 32'd0;
    end else if (clr_i) begin
      wr_idx_q <= 32'd0;
      rd_idx_q <= 32'd0;
    end else begin
      if (push_i) wr_idx_q <= bump(wr_idx_q);
      if (pop_i) rd_idx_q <= bump(rd_idx_q);
    end
  end

  // Payload ready once the FIFO is full or the image is complete
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      payload_q <= 1'b0;
    end else if (full_i || (image_activated_i && !empty_i)) begin
      payload_q <= 1'b1;
    end else if (empty_i) begin
      payload_q <= 1'b0;
    end
  end

  assign payload_available_o = payload_q;

  assign status_o.full   = full_i;
  assign status_o.empty  = empty_i;
  assign status_o.wr_idx = wr_idx_q;
  assign status_o.rd_idx = rd_idx_q;

endmodule

// ==== rec_pkg.sv ====
// Types only; selector order matters because the sequencer steps through multi-word registers
package rec_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [15:0] len_t;
  typedef logic [31:0] fifo_idx_t;

  // Recovery commands handled by the executor
  typedef enum logic [7:0] {
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } cmd_code_e;

  // One selector per 32-bit register word
  typedef enum logic [7:0] {
    SEL_DEVICE_RESET  = 8'd0,
    SEL_RECOVERY_CTRL = 8'd1,
    SEL_FIFO_CTRL_0   = 8'd2,
    SEL_FIFO_CTRL_1   = 8'd3,
    SEL_FIFO_STATUS_0 = 8'd4,
    SEL_FIFO_STATUS_1 = 8'd5,
    SEL_FIFO_STATUS_2 = 8'd6,
    SEL_FIFO_STATUS_3 = 8'd7,
    SEL_FIFO_STATUS_4 = 8'd8,
    SEL_INVALID       = 8'hFF
  } csr_sel_e;

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    FifoWrite,
    ReadWait,
    ReadLen,
    ReadData,
    Error,
    Done
  } seq_state_e;

  // Code is a plain byte so illegal codes can still be carried
  typedef struct packed {
    logic  is_rd;
    byte_t code;
    len_t  len;
    logic  err;
  } cmd_req_t;

  typedef struct packed {
    logic     we;
    csr_sel_e sel;
    word_t    data;
  } csr_wr_t;

  typedef struct packed {
    logic      full;
    logic      empty;
    fifo_idx_t wr_idx;
    fifo_idx_t rd_idx;
  } fifo_status_t;

  typedef struct packed {
    byte_t [2:0] device_reset;
    byte_t [2:0] recovery_ctrl;
    byte_t       fifo_cms;
    byte_t       fifo_reset;
    word_t       image_size;
  } rec_regs_t;

endpackage

// ==== rec_resp_mux.sv ====
// Purely combinational; bytes go out little-endian and unknown selectors read as zero
`timescale 1ns/10ps
`include "rec_cfg.svh"

module rec_resp_mux (
  input  rec_pkg::csr_sel_e      sel_i,
  input  logic [1:0]             byte_idx_i,
  input  rec_pkg::rec_regs_t     regs_i,
  input  rec_pkg::fifo_status_t  status_i,
  output rec_pkg::byte_t         res_data_o
);

  rec_pkg::word_t rd_word;

  always_comb begin
    rd_word = 32'd0;
    case (sel_i)
      rec_pkg::SEL_DEVICE_RESET: begin
        rd_word = {8'h00, regs_i.device_reset};
      end
      rec_pkg::SEL_RECOVERY_CTRL: begin
        rd_word = {8'h00, regs_i.recovery_ctrl};
      end
      rec_pkg::SEL_FIFO_CTRL_0: begin
        rd_word = {regs_i.image_size[15:0], regs_i.fifo_reset, regs_i.fifo_cms};
      end
      rec_pkg::SEL_FIFO_CTRL_1: begin
        rd_word = {16'h0000, regs_i.image_size[31:16]};
      end
      rec_pkg::SEL_FIFO_STATUS_0: begin
        // Empty in bit 0, full in bit 1
        rd_word = {30'd0, status_i.full, status_i.empty};
      end
      rec_pkg::SEL_FIFO_STATUS_1: begin
        rd_word = status_i.wr_idx;
      end
      rec_pkg::SEL_FIFO_STATUS_2: begin
        rd_word = status_i.rd_idx;
      end
      rec_pkg::SEL_FIFO_STATUS_3: begin
        rd_word = `REC_FIFO_DEPTH;
      end
      rec_pkg::SEL_FIFO_STATUS_4: begin
        rd_word = `REC_MAX_XFER_WORDS;
      end
      default: rd_word = 32'd0;
    endcase
  end

  // Byte lane picked by the sequencer's byte counter
  assign res_data_o = rd_word[{byte_idx_i, 3'b000} +: 8];

endmodule

// ==== run.sh ====
#!/bin/bash
# Build and run the executor testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert -j 0 --top-module tb_rec_executor \
  -f filelist.f -o sim_rec_executor

./obj_dir/sim_rec_executor | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// ==== tb_rec_executor.sv ====
// Table-driven run with random TTI latency and response stalls from a fixed seed; no host abort
`timescale 1ns/10ps
`include "rec_cfg.svh"

module tb_rec_executor;

  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 10;
  localparam int NUM_TESTS   = 18;
  localparam int WATCHDOG_NS = (RST_CYCLES + NUM_TESTS * 300) * CLK_PERIOD;

  // One table row; rd holds the expected response bytes little-endian from bit 0
  typedef struct packed {
    logic         is_rd;
    logic [7:0]   code;
    logic [15:0]  len;
    logic         err;
    logic         mode;
    logic [127:0] wr;
    logic [159:0] rd;
    logic [15:0]  exp_len;
    logic         exp_clr;
    logic         exp_fclr;
    logic [1:0]   pops;
    logic         exp_act;
    logic         exp_pay;
  } test_t;

  logic              clk_i;
  logic              rst_ni;
  logic              cmd_valid_i;
  rec_pkg::cmd_req_t cmd_i;
  logic              cmd_done_o;
  logic              recovery_mode_enabled_i;
  logic              host_abort_i;
  logic              tti_rx_rreq_o;
  logic              tti_rx_rack_i;
  rec_pkg::word_t    tti_rx_rdata_i;
  logic              res_valid_o;
  logic              res_ready_i;
  rec_pkg::len_t     res_len_o;
  logic              res_dvalid_o;
  logic              res_dready_i;
  rec_pkg::byte_t    res_data_o;
  logic              res_dlast_o;
  logic              rx_queue_clr_o;
  logic              indirect_rx_wvalid_o;
  rec_pkg::word_t    indirect_rx_wdata_o;
  logic              indirect_rx_rack_i;
  logic              indirect_rx_full_i;
  logic              indirect_rx_empty_i;
  logic              indirect_rx_clr_o;
  logic              payload_available_o;
  logic              image_activated_o;

  test_t          tab [NUM_TESTS];
  string          names [NUM_TESTS];
  int             seed = 32'h8f4aed1d;
  int             errors;
  int             n_pass;
  int             cur;
  int             rnd_lat;
  int             rnd_rdy;
  int             tti_wait;
  int             tti_idx;
  logic [127:0]   tti_words;
  int             fifo_count;
  rec_pkg::word_t push_q [$];

  rec_executor rec_executor_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // TTI RX queue, answers each request after 1 to 3 cycles
  always @(negedge clk_i) begin
    tti_rx_rack_i = 1'b0;
    if (tti_wait > 0) begin
      tti_wait = tti_wait - 1;
      if (tti_wait == 0) begin
        tti_rx_rack_i  = 1'b1;
        tti_rx_rdata_i = 32'(tti_words >> (32 * tti_idx));
        tti_idx        = tti_idx + 1;
      end
    end else if (tti_rx_rreq_o) begin
      rnd_lat  = $random(seed);
      tti_wait = 1 + ((rnd_lat & 32'h7fff_ffff) % 3);
    end
  end

  // Indirect FIFO model keeps only a word count and the pushed words
  always @(posedge clk_i) begin
    if (!rst_ni || indirect_rx_clr_o) begin
      fifo_count <= 0;
    end else begin
      if (indirect_rx_wvalid_o) push_q.push_back(indirect_rx_wdata_o);
      fifo_count <= fifo_count + 32'(indirect_rx_wvalid_o)
                  - 32'(indirect_rx_rack_i && (fifo_count != 0));
    end
  end

  always @(negedge clk_i) begin
    indirect_rx_full_i  = (fifo_count == `REC_FIFO_DEPTH);
    indirect_rx_empty_i = (fifo_count == 0);
  end

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", names[cur], what, exp, act);
      errors++;
    end
  endtask

  task automatic run_test(input int t);
    test_t tc;
    int    nwords;
    int    exp_req;
    int    exp_push;
    int    nb;
    int    n_req;
    int    n_clr;
    int    n_fclr;
    int    n_valid;
    int    errs_before;
    int    k;
    logic [15:0] got_len;
    logic  done;
    tc          = tab[t];
    cur         = t;
    errs_before = errors;
    nwords      = (32'(tc.len) + 3) / 4;
    exp_req     = (!tc.is_rd && !tc.exp_clr) ? nwords : 0;
    exp_push    = (tc.code == 8'd47) ? exp_req : 0;
    nb          = 0;
    n_req       = 0;
    n_clr       = 0;
    n_fclr      = 0;
    n_valid     = 0;
    got_len     = '0;
    done        = 1'b0;
    push_q.delete();
    tti_words   = tc.wr;
    tti_idx     = 0;
    cmd_i       = '{is_rd: tc.is_rd, code: tc.code, len: tc.len, err: tc.err};
    recovery_mode_enabled_i = tc.mode;
    res_ready_i = tc.is_rd;
    cmd_valid_i = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      n_req  += 32'(tti_rx_rreq_o);
      n_clr  += 32'(rx_queue_clr_o);
      n_fclr += 32'(indirect_rx_clr_o);
      if (res_valid_o) begin
        n_valid++;
        got_len = res_len_o;
      end
      if (res_dvalid_o && res_dready_i) begin
        if (nb < 32'(tc.exp_len)) begin
          check_val($sformatf("byte %0d", nb), 32'(8'(tc.rd >> (8 * nb))), 32'(res_data_o));
          check_val($sformatf("dlast at byte %0d", nb), 32'(nb == 32'(tc.exp_len) - 1),
                    32'(res_dlast_o));
        end
        nb++;
      end
      done = cmd_done_o;
      @(negedge clk_i);
      cmd_valid_i  = 1'b0;
      rnd_rdy      = $random(seed);
      res_dready_i = rnd_rdy[0];
    end
    res_ready_i = 1'b0;
    check_val("byte count", 32'(tc.exp_len), nb);
    check_val("res_valid count", 32'(tc.is_rd && !tc.exp_clr), n_valid);
    if (n_valid == 1) check_val("res_len", 32'(tc.exp_len), 32'(got_len));
    check_val("tti requests", exp_req, n_req);
    check_val("rx queue clears", 32'(tc.exp_clr), n_clr);
    check_val("indirect fifo clears", 32'(tc.exp_fclr), n_fclr);
    check_val("fifo pushes", exp_push, push_q.size());
    for (k = 0; k < push_q.size() && k < exp_push; k++) begin
      check_val($sformatf("pushed word %0d", k), 32'(tc.wr >> (32 * k)), push_q[k]);
    end
    // Consumer pops drain the indirect FIFO model
    for (k = 0; k < 32'(tc.pops); k++) begin
      indirect_rx_rack_i = 1'b1;
      @(negedge clk_i);
      indirect_rx_rack_i = 1'b0;
      @(negedge clk_i);
    end
    repeat (3) @(negedge clk_i);
    check_val("image_activated", 32'(tc.exp_act), 32'(image_activated_o));
    check_val("payload_available", 32'(tc.exp_pay), 32'(payload_available_o));
    if (errors == errs_before) n_pass++;
    $display("test %0d %s: %s", t, names[t], (errors == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic fill_table();
    names[0]  = "rc_write";
    tab[0]    = '{code: 8'd38, len: 16'd3, wr: 128'h00332211, default: '0};
    names[1]  = "rc_read";
    tab[1]    = '{is_rd: 1'b1, code: 8'd38, rd: 160'h00332211, exp_len: 16'd3, default: '0};
    names[2]  = "ctrl_write";
    tab[2]    = '{code: 8'd45, len: 16'd6, mode: 1'b1, wr: 128'hCDEF1234_56780001,
                  default: '0};
    names[3]  = "ctrl_read";
    tab[3]    = '{is_rd: 1'b1, code: 8'd45, mode: 1'b1, rd: 160'h00001234_56780001,
                  exp_len: 16'd6, default: '0};
    names[4]  = "data_write";
    tab[4]    = '{code: 8'd47, len: 16'd12, mode: 1'b1,
                  wr: 128'h00000000_C0DE0003_C0DE0002_C0DE0001, default: '0};
    names[5]  = "status_read";
    tab[5]    = '{is_rd: 1'b1, code: 8'd46, mode: 1'b1, exp_len: 16'd20,
                  rd: {32'd64, 32'd64, 32'd0, 32'd3, 32'd0}, default: '0};
    names[6]  = "bad_code";
    tab[6]    = '{code: 8'd40, len: 16'd4, mode: 1'b1, exp_clr: 1'b1, default: '0};
    names[7]  = "err_flag";
    tab[7]    = '{is_rd: 1'b1, code: 8'd38, err: 1'b1, exp_clr: 1'b1, default: '0};
    names[8]  = "ctrl_no_mode";
    tab[8]    = '{code: 8'd45, len: 16'd6, exp_clr: 1'b1, default: '0};
    names[9]  = "data_read";
    tab[9]    = '{is_rd: 1'b1, code: 8'd47, mode: 1'b1, exp_clr: 1'b1, default: '0};
    names[10] = "fifo_reset";
    tab[10]   = '{code: 8'd45, len: 16'd4, mode: 1'b1, wr: 128'h56780101, exp_fclr: 1'b1,
                  default: '0};
    names[11] = "status_cleared";
    tab[11]   = '{is_rd: 1'b1, code: 8'd46, mode: 1'b1, exp_len: 16'd20,
                  rd: {32'd64, 32'd64, 32'd0, 32'd0, 32'd1}, default: '0};
    names[12] = "ctrl_cleared";
    tab[12]   = '{is_rd: 1'b1, code: 8'd45, mode: 1'b1, rd: 160'h00001234_56780001,
                  exp_len: 16'd6, default: '0};
    names[13] = "refill";
    tab[13]   = '{code: 8'd47, len: 16'd8, mode: 1'b1, wr: 128'hBEEF0002_BEEF0001,
                  default: '0};
    names[14] = "activate";
    tab[14]   = '{code: 8'd38, len: 16'd3, wr: 128'h000F2211, exp_act: 1'b1, exp_pay: 1'b1,
                  default: '0};
    names[15] = "drain";
    tab[15]   = '{is_rd: 1'b1, code: 8'd38, rd: 160'h000F2211, exp_len: 16'd3, pops: 2'd2,
                  exp_act: 1'b1, default: '0};
    names[16] = "status_drained";
    tab[16]   = '{is_rd: 1'b1, code: 8'd46, mode: 1'b1, exp_len: 16'd20, exp_act: 1'b1,
                  rd: {32'd64, 32'd64, 32'd2, 32'd2, 32'd1}, default: '0};
    names[17] = "zero_len";
    tab[17]   = '{code: 8'd37, exp_act: 1'b1, default: '0};
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst_ni                  = 1'b0;
    cmd_valid_i             = 1'b0;
    cmd_i                   = '0;
    recovery_mode_enabled_i = 1'b0;
    host_abort_i            = 1'b0;
    tti_rx_rack_i           = 1'b0;
    tti_rx_rdata_i          = '0;
    res_ready_i             = 1'b0;
    res_dready_i            = 1'b0;
    indirect_rx_rack_i      = 1'b0;
    indirect_rx_full_i      = 1'b0;
    indirect_rx_empty_i     = 1'b1;
    tti_wait                = 0;
    tti_idx                 = 0;
    tti_words               = '0;
    errors                  = 0;
    n_pass                  = 0;
    cur                     = 0;
    fill_table();
    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d ok, %0d with mismatches, %0d check errors",
             NUM_TESTS, n_pass, NUM_TESTS - n_pass, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
